/* tb.f */
source/offload_pkg.sv
source/unit_req_if.sv
source/unit_rsp_if.sv
source/op_dispatch.sv
source/muldiv_unit.sv
source/accel_unit.sv
source/wb_arbiter.sv
source/offload_top.sv
bench/offload_tb.sv

/* bench/offload_tb.sv */
`timescale 1ns/1ps

module offload_tb;
    import offload_pkg::*;

    localparam int accel_latency = 4;
    localparam int n_pairs = 7;
    localparam int n_random = 300;
    localparam int n_issues = 2 * 8 * n_pairs + 2 + n_random;
    localparam int timeout_cycles = n_issues * (xlen + 8) + 200;

    logic                clk;
    logic                rst_n;
    logic                issue;
    hart_id_t            issue_hart;
    logic [31:0]         issue_inst;
    xlen_t               rs1_val;
    xlen_t               rs2_val;
    logic [hart_num-1:0] hart_blocked;
    logic                muldiv_busy;
    logic                accel_busy;
    logic                wb_we;
    hart_id_t            wb_hart;
    reg_addr_t           wb_rd;
    xlen_t               wb_data;

    // expected result per hart and the unit that computes it.
    logic [hart_num-1:0] exp_valid;
    logic [hart_num-1:0] exp_unit;
    logic [hart_num-1:0] blocked_m;
    reg_addr_t           exp_rd [hart_num];
    xlen_t               exp_data [hart_num];
    int                  exp_ready [hart_num];
    logic                md_start;
    logic                ac_start;
    // cycles each unit still stays busy.
    int                  md_left;
    int                  ac_left;
    int                  cycles = 0;

    xlen_t corner_a [n_pairs] = '{32'h8000_0000, 32'h1234_5678, 32'h0, 32'h7fff_ffff,
                                  32'h8000_0000, 32'hffff_ffff, 32'hfedc_ba98};
    xlen_t corner_b [n_pairs] = '{32'hffff_ffff, 32'h0, 32'h0, 32'h7fff_ffff,
                                  32'h8000_0000, 32'hffff_ffff, 32'h0000_0007};

    offload_top #(
        .accel_latency(accel_latency)
    ) uut (
        .clk(clk),
        .rst_n(rst_n),
        .issue(issue),
        .issue_hart(issue_hart),
        .issue_inst(issue_inst),
        .rs1_val(rs1_val),
        .rs2_val(rs2_val),
        .hart_blocked(hart_blocked),
        .muldiv_busy(muldiv_busy),
        .accel_busy(accel_busy),
        .wb_we(wb_we),
        .wb_hart(wb_hart),
        .wb_rd(wb_rd),
        .wb_data(wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    function automatic xlen_t muldiv_ref(input logic [2:0] f3, input xlen_t a, input xlen_t b);
        logic [2*xlen-1:0] sa;
        logic [2*xlen-1:0] sb;
        logic [2*xlen-1:0] za;
        logic [2*xlen-1:0] zb;
        logic [2*xlen-1:0] p;
        xlen_t             r;
        sa = {{xlen{a[xlen-1]}}, a};
        sb = {{xlen{b[xlen-1]}}, b};
        za = {{xlen{1'b0}}, a};
        zb = {{xlen{1'b0}}, b};
        case (muldiv_op_e'(f3))
            mul: begin
                p = za * zb;
                r = p[xlen-1:0];
            end
            mulh: begin
                p = sa * sb;
                r = p[2*xlen-1:xlen];
            end
            mulhsu: begin
                p = sa * zb;
                r = p[2*xlen-1:xlen];
            end
            mulhu: begin
                p = za * zb;
                r = p[2*xlen-1:xlen];
            end
            div: begin
                if (b == '0) r = '1;
                else if (a == {1'b1, {(xlen-1){1'b0}}} && b == '1) r = a;
                else r = $signed(a) / $signed(b);
            end
            divu:    r = (b == '0) ? '1 : a / b;
            rem: begin
                if (b == '0) r = a;
                else if (a == {1'b1, {(xlen-1){1'b0}}} && b == '1) r = '0;
                else r = $signed(a) % $signed(b);
            end
            default: r = (b == '0) ? a : a % b;
        endcase
        return r;
    endfunction

    function automatic xlen_t accel_ref(input logic [2:0] f3, input xlen_t a, input xlen_t b);
        xlen_t r;
        case (accel_op_e'(f3))
            popc: r = $countones(a);
            clz: begin
                // the highest set bit is found last.
                r = xlen;
                for (int i = 0; i < xlen; i++) begin
                    if (a[i]) r = xlen - 1 - i;
                end
            end
            brev:    r = {<<{a}};
            bswap:   r = {<<8{a}};
            min:     r = ($signed(a) < $signed(b)) ? a : b;
            max:     r = ($signed(a) > $signed(b)) ? a : b;
            minu:    r = (a < b) ? a : b;
            default: r = (a > b) ? a : b;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] make_inst(input logic [6:0] funct7, input logic [2:0] funct3,
                                              input reg_addr_t rd, input logic [6:0] opcode);
        return {funct7, 5'd2, 5'd1, funct3, rd, opcode};
    endfunction

    function automatic xlen_t rand_operand();
        if ($urandom_range(0, 3) == 0) begin
            return corner_a[$urandom_range(0, n_pairs - 1)];
        end
        return $urandom;
    endfunction

    task automatic drive_issue(input hart_id_t h, input logic [31:0] inst,
                               input xlen_t a, input xlen_t b);
        @(posedge clk);
        issue      <= 1'b1;
        issue_hart <= h;
        issue_inst <= inst;
        rs1_val    <= a;
        rs2_val    <= b;
        @(posedge clk);
        issue <= 1'b0;
    endtask

    task automatic wait_idle();
        do @(posedge clk); while (exp_valid != '0);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Run timed out after %0d cycles with results still outstanding", cycles);
            abort_run();
        end
    end

    // reference model of the issue rule, the busy levels and the writeback timing.
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_valid <= '0;
            blocked_m <= '0;
            md_start  <= 1'b0;
            ac_start  <= 1'b0;
            md_left   <= 0;
            ac_left   <= 0;
        end else begin
            md_start <= 1'b0;
            ac_start <= 1'b0;
            if (md_start) begin
                md_left <= xlen;
            end else if (md_left != 0) begin
                md_left <= md_left - 1;
            end
            if (ac_start) begin
                ac_left <= accel_latency - 1;
            end else if (ac_left != 0) begin
                ac_left <= ac_left - 1;
            end
            if (wb_we) begin
                exp_valid[wb_hart] <= 1'b0;
                blocked_m[wb_hart] <= 1'b0;
            end
            if (issue && !hart_blocked[issue_hart]) begin
                if (issue_inst[6:0] == opcode_op && issue_inst[31:25] == funct7_muldiv &&
                    !muldiv_busy && !md_start) begin
                    md_start                <= 1'b1;
                    exp_valid[issue_hart]   <= 1'b1;
                    blocked_m[issue_hart]   <= 1'b1;
                    exp_unit[issue_hart]    <= 1'b0;
                    exp_rd[issue_hart]      <= issue_inst[11:7];
                    exp_data[issue_hart]    <= muldiv_ref(issue_inst[14:12], rs1_val, rs2_val);
                    exp_ready[issue_hart]   <= cycles + xlen + 3;
                end else if (issue_inst[6:0] == opcode_custom1 && !accel_busy && !ac_start) begin
                    ac_start                <= 1'b1;
                    exp_valid[issue_hart]   <= 1'b1;
                    blocked_m[issue_hart]   <= 1'b1;
                    exp_unit[issue_hart]    <= 1'b1;
                    exp_rd[issue_hart]      <= issue_inst[11:7];
                    exp_data[issue_hart]    <= accel_ref(issue_inst[14:12], rs1_val, rs2_val);
                    exp_ready[issue_hart]   <= cycles + accel_latency + 2;
                end
            end
        end
    end

    a_reset_state: assert property (@(posedge clk)
        (cycles != 0 && (!rst_n || $past(!rst_n))) |->
            (!wb_we && hart_blocked == '0 && !muldiv_busy && !accel_busy))
    else begin
        $display("Error: wb_we=%h hart_blocked=%h muldiv_busy=%h accel_busy=%h around reset",
                 $sampled(wb_we), $sampled(hart_blocked), $sampled(muldiv_busy),
                 $sampled(accel_busy));
        abort_run();
    end

    a_blocked: assert property (@(posedge clk) disable iff (!rst_n) hart_blocked == blocked_m)
    else begin
        $display("Error: hart_blocked=%h expected %h", $sampled(hart_blocked),
                 $sampled(blocked_m));
        abort_run();
    end

    a_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (muldiv_busy == (md_left != 0)) && (accel_busy == (ac_left != 0)))
    else begin
        $display("Error: muldiv_busy=%h expected %h accel_busy=%h expected %h",
                 $sampled(muldiv_busy), $sampled(md_left != 0),
                 $sampled(accel_busy), $sampled(ac_left != 0));
        abort_run();
    end

    a_wb_pending: assert property (@(posedge clk) disable iff (!rst_n)
        wb_we |-> exp_valid[wb_hart])
    else begin
        $display("Writeback to hart %0d with no result outstanding for it", $sampled(wb_hart));
        abort_run();
    end

    a_wb_rd: assert property (@(posedge clk) disable iff (!rst_n)
        wb_we |-> wb_rd == exp_rd[wb_hart])
    else begin
        $display("Error: wb_rd=%h expected %h", $sampled(wb_rd), $sampled(exp_rd[wb_hart]));
        abort_run();
    end

    a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
        wb_we |-> wb_data == exp_data[wb_hart])
    else begin
        $display("Error: wb_data=%h expected %h", $sampled(wb_data),
                 $sampled(exp_data[wb_hart]));
        abort_run();
    end

    a_wb_early: assert property (@(posedge clk) disable iff (!rst_n)
        wb_we |-> exp_ready[wb_hart] <= cycles)
    else begin
        $display("Writeback for hart %0d came before its unit could have finished",
                 $sampled(wb_hart));
        abort_run();
    end

    // a ready muldiv slot must win over the accelerator.
    a_wb_order: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_we && exp_unit[wb_hart]) |->
            !(exp_valid[!wb_hart] && !exp_unit[!wb_hart] && exp_ready[!wb_hart] <= cycles))
    else begin
        $display("Accelerator result was written while a muldiv result was pending");
        abort_run();
    end

    initial begin
        int          kind;
        logic [6:0]  f7;
        logic [6:0]  opc;
        void'($urandom(32'hb9ae72be));
        rst_n      = 1'b0;
        issue      = 1'b0;
        issue_hart = '0;
        issue_inst = '0;
        rs1_val    = '0;
        rs2_val    = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // every op against the corner operand pairs with one unit per hart.
        for (int p = 0; p < n_pairs; p++) begin
            for (int f = 0; f < 8; f++) begin
                drive_issue(0, make_inst(funct7_muldiv, 3'(f), reg_addr_t'(p * 8 + f), opcode_op),
                            corner_a[p], corner_b[p]);
                drive_issue(1, make_inst(7'd0, 3'(f), reg_addr_t'(f + 1), opcode_custom1),
                            corner_a[p], corner_b[p]);
                wait_idle();
            end
        end

        // both units finish in the same cycle.
        drive_issue(0, make_inst(funct7_muldiv, 3'd1, 5'd9, opcode_op), $urandom, $urandom);
        repeat (xlen - accel_latency - 1) @(posedge clk);
        drive_issue(1, make_inst(7'd0, 3'd4, 5'd10, opcode_custom1), $urandom, $urandom);
        wait_idle();

        for (int n = 0; n < n_random; n++) begin
            kind = $urandom_range(0, 19);
            f7 = funct7_muldiv;
            opc = opcode_op;
            if (kind >= 9 && kind < 17) begin
                f7 = 7'($urandom);
                opc = opcode_custom1;
            end else if (kind == 17) begin
                f7 = 7'b0100000;
            end else if (kind >= 18) begin
                opc = (kind == 18) ? 7'b0001011 : 7'b0010011;
            end
            @(posedge clk);
            issue      <= 1'($urandom_range(0, 1));
            issue_hart <= hart_id_t'($urandom_range(0, hart_num - 1));
            issue_inst <= make_inst(f7, 3'($urandom), reg_addr_t'($urandom), opc);
            rs1_val    <= rand_operand();
            rs2_val    <= rand_operand();
        end
        @(posedge clk);
        issue <= 1'b0;
        wait_idle();
        repeat (2) @(posedge clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* source/offload_top.sv */
`timescale 1ns/1ps

module offload_top #(
    parameter int accel_latency = 4
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             issue,
    input  offload_pkg::hart_id_t            issue_hart,
    input  logic [31:0]                      issue_inst,
    input  offload_pkg::xlen_t               rs1_val,
    input  offload_pkg::xlen_t               rs2_val,
    output logic [offload_pkg::hart_num-1:0] hart_blocked,
    output logic                             muldiv_busy,
    output logic                             accel_busy,
    output logic                             wb_we,
    output offload_pkg::hart_id_t            wb_hart,
    output offload_pkg::reg_addr_t           wb_rd,
    output offload_pkg::xlen_t               wb_data
);

    unit_req_if muldiv_req ();
    unit_req_if accel_req ();
    unit_rsp_if muldiv_rsp ();
    unit_rsp_if accel_rsp ();

    assign muldiv_busy = muldiv_rsp.busy;
    assign accel_busy  = accel_rsp.busy;

    op_dispatch u_dispatch (
        .clk(clk),
        .rst_n(rst_n),
        .issue(issue),
        .issue_hart(issue_hart),
        .issue_inst(issue_inst),
        .rs1_val(rs1_val),
        .rs2_val(rs2_val),
        .wb_we(wb_we),
        .wb_hart(wb_hart),
        .muldiv_req(muldiv_req.dispatch),
        .accel_req(accel_req.dispatch),
        .muldiv_rsp(muldiv_rsp.dispatch),
        .accel_rsp(accel_rsp.dispatch),
        .hart_blocked(hart_blocked)
    );

    muldiv_unit u_muldiv (
        .clk(clk),
        .rst_n(rst_n),
        .req(muldiv_req.unit),
        .rsp(muldiv_rsp.unit)
    );

    accel_unit #(
        .accel_latency(accel_latency)
    ) u_accel (
        .clk(clk),
        .rst_n(rst_n),
        .req(accel_req.unit),
        .rsp(accel_rsp.unit)
    );

    wb_arbiter u_arbiter (
        .clk(clk),
        .rst_n(rst_n),
        .muldiv_rsp(muldiv_rsp.arbiter),
        .accel_rsp(accel_rsp.arbiter),
        .wb_we(wb_we),
        .wb_hart(wb_hart),
        .wb_rd(wb_rd),
        .wb_data(wb_data)
    );

endmodule

/* source/wb_arbiter.sv */
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    unit_rsp_if.arbiter            muldiv_rsp,
    unit_rsp_if.arbiter            accel_rsp,
    output logic                   wb_we,
    output offload_pkg::hart_id_t  wb_hart,
    output offload_pkg::reg_addr_t wb_rd,
    output offload_pkg::xlen_t     wb_data
);
    import offload_pkg::*;

    // slot 0 holds muldiv, slot 1 holds the accelerator.
    logic [1:0] cap_done;
    xlen_t      cap_result [2];
    hart_id_t   cap_hart [2];
    reg_addr_t  cap_rd [2];

    logic [1:0] slot_valid;
    xlen_t      slot_result [2];
    hart_id_t   slot_hart [2];
    reg_addr_t  slot_rd [2];
    logic [1:0] slot_fire;
    int         sel;

    assign cap_done      = {accel_rsp.done, muldiv_rsp.done};
    assign cap_result[0] = muldiv_rsp.result;
    assign cap_result[1] = accel_rsp.result;
    assign cap_hart[0]   = muldiv_rsp.hart;
    assign cap_hart[1]   = accel_rsp.hart;
    assign cap_rd[0]     = muldiv_rsp.rd;
    assign cap_rd[1]     = accel_rsp.rd;

    // muldiv wins when both slots are occupied.
    assign slot_fire[0] = slot_valid[0];
    assign slot_fire[1] = slot_valid[1] && !slot_valid[0];
    assign sel          = slot_valid[0] ? 0 : 1;

    assign wb_we   = |slot_valid;
    assign wb_hart = slot_hart[sel];
    assign wb_rd   = slot_rd[sel];
    assign wb_data = slot_result[sel];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_valid <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (cap_done[i]) begin
                    slot_valid[i] <= 1'b1;
                end else if (slot_fire[i]) begin
                    slot_valid[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (cap_done[i]) begin
                slot_result[i] <= cap_result[i];
                slot_hart[i]   <= cap_hart[i];
                slot_rd[i]     <= cap_rd[i];
            end
        end
    end

endmodule

/* source/accel_unit.sv */
`timescale 1ns/1ps

module accel_unit #(
    parameter int accel_latency = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    unit_req_if.unit req,
    unit_rsp_if.unit rsp
);
    import offload_pkg::*;

    localparam int cnt_w = $clog2(accel_latency + 1);

    accel_op_e        op_in;
    xlen_t            result_in;
    logic [cnt_w-1:0] cnt;
    logic             seen_one;

    assign op_in = accel_op_e'(req.op);

    always_comb begin
        result_in = '0;
        seen_one  = 1'b0;
        case (op_in)
            popc: begin
                for (int i = 0; i < xlen; i++) begin
                    result_in = result_in + xlen_t'(req.a[i]);
                end
            end
            clz: begin
                // zeros above the first one, xlen for a zero word.
                for (int i = xlen - 1; i >= 0; i--) begin
                    seen_one = seen_one | req.a[i];
                    result_in = result_in + xlen_t'(!seen_one);
                end
            end
            brev: begin
                for (int i = 0; i < xlen; i++) begin
                    result_in[i] = req.a[xlen-1-i];
                end
            end
            bswap:   result_in = {req.a[7:0], req.a[15:8], req.a[23:16], req.a[31:24]};
            min:     result_in = ($signed(req.a) < $signed(req.b)) ? req.a : req.b;
            max:     result_in = ($signed(req.a) < $signed(req.b)) ? req.b : req.a;
            minu:    result_in = (req.a < req.b) ? req.a : req.b;
            default: result_in = (req.a < req.b) ? req.b : req.a;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp.busy <= 1'b0;
            rsp.done <= 1'b0;
            cnt      <= '0;
        end else begin
            rsp.done <= 1'b0;
            if (req.start) begin
                rsp.busy <= 1'b1;
                cnt      <= cnt_w'(accel_latency - 1);
            end else if (rsp.busy) begin
                cnt <= cnt - 1'b1;
                if (cnt == cnt_w'(1)) begin
                    rsp.busy <= 1'b0;
                    rsp.done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.start) begin
            rsp.result <= result_in;
            rsp.hart   <= req.hart;
            rsp.rd     <= req.rd;
        end
    end

endmodule

/* source/muldiv_unit.sv */
`timescale 1ns/1ps

module muldiv_unit (
    input  logic     clk,
    input  logic     rst_n,
    unit_req_if.unit req,
    unit_rsp_if.unit rsp
);
    import offload_pkg::*;

    localparam int cnt_w = $clog2(xlen);

    muldiv_op_e          op_in;
    logic                a_signed;
    logic                b_signed;
    logic                a_neg;
    logic                b_neg;
    logic                in_div;
    xlen_t               a_abs;
    xlen_t               b_abs;

    muldiv_op_e          op_q;
    logic                neg_q;
    logic                neg_r_q;
    xlen_t               opb;
    logic [2*xlen-1:0]   acc;
    logic [2*xlen-1:0]   acc_next;
    logic [xlen:0]       mul_sum;
    logic [xlen+1:0]     div_diff;
    logic [cnt_w-1:0]    step_cnt;
    logic                last_step;

    logic [2*xlen-1:0]   prod_fix;
    xlen_t               quo_fix;
    xlen_t               rem_fix;
    xlen_t               result_next;

    // operand preparation at start.
    assign op_in    = muldiv_op_e'(req.op);
    assign a_signed = op_in inside {mulh, mulhsu, div, rem};
    assign b_signed = op_in inside {mulh, div, rem};
    assign in_div   = op_in inside {div, divu, rem, remu};
    assign a_neg    = a_signed && req.a[xlen-1];
    assign b_neg    = b_signed && req.b[xlen-1];
    assign a_abs    = a_neg ? -req.a : req.a;
    assign b_abs    = b_neg ? -req.b : req.b;

    // one shift-add or restore-subtract step per cycle.
    always_comb begin
        mul_sum  = {1'b0, acc[2*xlen-1:xlen]} + (acc[0] ? {1'b0, opb} : '0);
        div_diff = {1'b0, acc[2*xlen-1:xlen-1]} - {2'b00, opb};
        if (op_q inside {div, divu, rem, remu}) begin
            if (!div_diff[xlen+1]) begin
                acc_next = {div_diff[xlen-1:0], acc[xlen-2:0], 1'b1};
            end else begin
                acc_next = {acc[2*xlen-2:0], 1'b0};
            end
        end else begin
            acc_next = {mul_sum, acc[xlen-1:1]};
        end
    end

    // sign fix on the final step.
    assign prod_fix = neg_q ? -acc_next : acc_next;
    assign quo_fix  = neg_q ? -acc_next[xlen-1:0] : acc_next[xlen-1:0];
    assign rem_fix  = neg_r_q ? -acc_next[2*xlen-1:xlen] : acc_next[2*xlen-1:xlen];

    always_comb begin
        case (op_q)
            mul:                 result_next = acc_next[xlen-1:0];
            mulh, mulhsu, mulhu: result_next = prod_fix[2*xlen-1:xlen];
            div, divu:           result_next = quo_fix;
            default:             result_next = rem_fix;
        endcase
    end

    assign last_step = (step_cnt == cnt_w'(xlen - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp.busy <= 1'b0;
            rsp.done <= 1'b0;
            step_cnt <= '0;
        end else begin
            rsp.done <= 1'b0;
            if (req.start) begin
                rsp.busy <= 1'b1;
                step_cnt <= '0;
            end else if (rsp.busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (last_step) begin
                    rsp.busy <= 1'b0;
                    rsp.done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.start) begin
            op_q     <= op_in;
            // a zero divisor keeps the all-ones quotient unsigned.
            neg_q    <= (a_neg ^ b_neg) && !(in_div && (req.b == '0));
            neg_r_q  <= a_neg;
            acc      <= {{xlen{1'b0}}, (in_div ? a_abs : b_abs)};
            opb      <= in_div ? b_abs : a_abs;
            rsp.hart <= req.hart;
            rsp.rd   <= req.rd;
        end else if (rsp.busy) begin
            acc <= acc_next;
            if (last_step) begin
                rsp.result <= result_next;
            end
        end
    end

endmodule

/* source/op_dispatch.sv */
`timescale 1ns/1ps

module op_dispatch (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             issue,
    input  offload_pkg::hart_id_t            issue_hart,
    input  logic [31:0]                      issue_inst,
    input  offload_pkg::xlen_t               rs1_val,
    input  offload_pkg::xlen_t               rs2_val,
    input  logic                             wb_we,
    input  offload_pkg::hart_id_t            wb_hart,
    unit_req_if.dispatch                     muldiv_req,
    unit_req_if.dispatch                     accel_req,
    unit_rsp_if.dispatch                     muldiv_rsp,
    unit_rsp_if.dispatch                     accel_rsp,
    output logic [offload_pkg::hart_num-1:0] hart_blocked
);
    import offload_pkg::*;

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic       is_muldiv;
    logic       is_accel;
    muldiv_op_e md_op;
    accel_op_e  ac_op;
    logic       muldiv_free;
    logic       accel_free;
    logic       hart_free;
    logic       muldiv_accept;
    logic       accel_accept;

    assign opcode = issue_inst[6:0];
    assign rd     = issue_inst[11:7];
    assign funct3 = issue_inst[14:12];
    assign funct7 = issue_inst[31:25];

    assign is_muldiv = (opcode == opcode_op) && (funct7 == funct7_muldiv);
    assign is_accel  = (opcode == opcode_custom1);
    assign md_op     = muldiv_op_e'(funct3);
    assign ac_op     = accel_op_e'(funct3);

    // busy only rises the cycle after start, so a pending start counts too.
    assign muldiv_free = !muldiv_rsp.busy && !muldiv_req.start;
    assign accel_free  = !accel_rsp.busy && !accel_req.start;
    assign hart_free   = !hart_blocked[issue_hart];

    assign muldiv_accept = issue && is_muldiv && hart_free && muldiv_free;
    assign accel_accept  = issue && is_accel && hart_free && accel_free;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            muldiv_req.start <= 1'b0;
            accel_req.start  <= 1'b0;
            hart_blocked     <= '0;
        end else begin
            muldiv_req.start <= muldiv_accept;
            accel_req.start  <= accel_accept;
            if (wb_we) begin
                hart_blocked[wb_hart] <= 1'b0;
            end
            if (muldiv_accept || accel_accept) begin
                hart_blocked[issue_hart] <= 1'b1;
            end
        end
    end

    // operands only matter while start is high.
    always_ff @(posedge clk) begin
        if (muldiv_accept) begin
            muldiv_req.op   <= md_op;
            muldiv_req.a    <= rs1_val;
            muldiv_req.b    <= rs2_val;
            muldiv_req.hart <= issue_hart;
            muldiv_req.rd   <= rd;
        end
        if (accel_accept) begin
            accel_req.op   <= ac_op;
            accel_req.a    <= rs1_val;
            accel_req.b    <= rs2_val;
            accel_req.hart <= issue_hart;
            accel_req.rd   <= rd;
        end
    end

endmodule

/* source/unit_rsp_if.sv */
`timescale 1ns/1ps

interface unit_rsp_if;
    import offload_pkg::*;

    logic      busy;
    logic      done;
    xlen_t     result;
    hart_id_t  hart;
    reg_addr_t rd;

    modport unit (output busy, output done, output result, output hart, output rd);

    // the arbiter only sees finished results.
    modport arbiter (input done, input result, input hart, input rd);

    modport dispatch (input busy);

endinterface

/* source/unit_req_if.sv */
`timescale 1ns/1ps

interface unit_req_if;
    import offload_pkg::*;

    // start is a one-cycle pulse, the rest is valid only with it.
    logic      start;
    logic [2:0] op;
    xlen_t     a;
    xlen_t     b;
    hart_id_t  hart;
    reg_addr_t rd;

    modport dispatch (output start, output op, output a, output b, output hart, output rd);

    modport unit (input start, input op, input a, input b, input hart, input rd);

endinterface

/* source/offload_pkg.sv */
package offload_pkg;

    // data word and hart numbering.
    localparam int xlen = 32;
    localparam int hart_num = 2;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [$clog2(hart_num)-1:0] hart_id_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // opcode fields of the offloaded instructions.
    localparam logic [6:0] opcode_op = 7'b0110011;
    localparam logic [6:0] funct7_muldiv = 7'b0000001;
    localparam logic [6:0] opcode_custom1 = 7'b0101011;

    // M extension ops, encoded as funct3.
    typedef enum logic [2:0] {
        mul    = 3'd0,
        mulh   = 3'd1,
        mulhsu = 3'd2,
        mulhu  = 3'd3,
        div    = 3'd4,
        divu   = 3'd5,
        rem    = 3'd6,
        remu   = 3'd7
    } muldiv_op_e;

    // custom-1 accelerator ops, encoded as funct3.
    typedef enum logic [2:0] {
        popc  = 3'd0,
        clz   = 3'd1,
        brev  = 3'd2,
        bswap = 3'd3,
        min   = 3'd4,
        max   = 3'd5,
        minu  = 3'd6,
        maxu  = 3'd7
    } accel_op_e;

endpackage
